/* mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// ****************************************
// data memory geometry
// ****************************************

// log2 of the number of 64-bit words in data_mem
// 10 gives 1024 doublewords, 8 KiB
`define MEM_DEPTH_LOG2 10

// first address bit of the word index
// bits below it pick the byte lane inside a doubleword
`define MEM_INDEX_LSB 3

// the index is MEM_DEPTH_LOG2 bits wide, taken from MEM_INDEX_LSB upward
// upper address bits are ignored, so addresses wrap modulo the memory size

// byte offset inside a doubleword is always addr[2:0]
// any access must be naturally aligned to its size

`endif

/* mem_stage_pkg.sv */
package mem_stage_pkg;

    // ****************************************
    // operations seen by the memory stage
    // ****************************************

    // compact encoding, one code per write-back rule
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ALU  = 4'd1,
        OP_LINK = 4'd2,
        OP_CSR  = 4'd3,
        OP_LB   = 4'd4,
        OP_LH   = 4'd5,
        OP_LW   = 4'd6,
        OP_LD   = 4'd7,
        OP_LBU  = 4'd8,
        OP_LHU  = 4'd9,
        OP_LWU  = 4'd10,
        OP_SB   = 4'd11,
        OP_SH   = 4'd12,
        OP_SW   = 4'd13,
        OP_SD   = 4'd14
    } mem_op_t;

    // ****************************************
    // stage bundles
    // ****************************************

    // from execute, 229 bits
    typedef struct packed {
        logic        spare;
        logic [63:0] pc;
        logic [31:0] inst;
        mem_op_t     op;
        // address for loads and stores
        logic [63:0] alu_out;
        // store data, or csr read value
        logic [63:0] src2;
    } ex_mem_t;

    // to write-back
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
        logic        reg_wen;
        logic [4:0]  reg_rd;
        logic [63:0] reg_value;
    } mem_wb_t;

    // single-cycle request into data_mem
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
    } mem_req_t;

    function automatic logic op_is_load(input mem_op_t op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    endfunction

    function automatic logic op_is_store(input mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    // natural alignment of a byte offset for the access size of op
    function automatic logic op_aligned(input mem_op_t op, input logic [2:0] offset);
        logic [2:0] mask;
        case (op)
            OP_LH, OP_LHU, OP_SH: mask = 3'b001;
            OP_LW, OP_LWU, OP_SW: mask = 3'b011;
            OP_LD, OP_SD:         mask = 3'b111;
            // bytes and non-memory ops never misalign
            default:              mask = 3'b000;
        endcase
        return (offset & mask) == 3'b000;
    endfunction

endpackage

/* store_align.sv */
module store_align import mem_stage_pkg::*; (
    input  mem_op_t     op,
    input  logic [2:0]  offset,
    input  logic [63:0] src2,
    output logic [63:0] wdata,
    output logic [7:0]  wstrb
);

    // ****************************************
    // lane steering
    // ****************************************

    // bit shift for the byte offset
    logic [5:0]  shamt;
    // src2 cut down to the access size, still in lane 0
    logic [63:0] narrow;
    // strobe pattern before the shift
    logic [7:0]  base_strb;

    assign shamt = {offset, 3'b000};

    always_comb begin
        case (op)
            OP_SB: begin
                narrow    = {56'd0, src2[7:0]};
                base_strb = 8'h01;
            end
            OP_SH: begin
                narrow    = {48'd0, src2[15:0]};
                base_strb = 8'h03;
            end
            OP_SW: begin
                narrow    = {32'd0, src2[31:0]};
                base_strb = 8'h0f;
            end
            OP_SD: begin
                // full doubleword, offset is zero when aligned
                narrow    = src2;
                base_strb = 8'hff;
            end
            default: begin
                // loads and non-memory ops write nothing
                narrow    = '0;
                base_strb = 8'h00;
            end
        endcase
    end

    // move data and strobe up to the addressed lane
    assign wdata = narrow << shamt;
    assign wstrb = base_strb << offset;

    // ****************************************
    // checks
    // ****************************************

    // a halfword at offset 7 would spill out of the doubleword
    always_comb begin
        if (op_is_store(op)) begin
            assert final (op_aligned(op, offset))
                else $error("store_align: misaligned store at offset %0d", offset);
        end
    end

endmodule

/* load_extract.sv */
module load_extract import mem_stage_pkg::*; (
    input  mem_op_t     op,
    input  logic [2:0]  offset,
    input  logic [63:0] rdata,
    output logic [63:0] value
);

    // ****************************************
    // lane selection
    // ****************************************

    // addressed lane moved down to bit 0
    logic [63:0] lane;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;

    // aligned accesses never cross the top of the doubleword
    assign lane   = rdata >> {offset, 3'b000};
    assign lane_b = lane[7:0];
    assign lane_h = lane[15:0];
    assign lane_w = lane[31:0];

    // ****************************************
    // extension
    // ****************************************

    always_comb begin
        case (op)
            // signed, replicate the top bit of the lane
            OP_LB: begin
                value = {{56{lane_b[7]}}, lane_b};
            end
            OP_LH: begin
                value = {{48{lane_h[15]}}, lane_h};
            end
            OP_LW: begin
                value = {{32{lane_w[31]}}, lane_w};
            end
            // unsigned, zero fill
            OP_LBU: begin
                value = {56'd0, lane_b};
            end
            OP_LHU: begin
                value = {48'd0, lane_h};
            end
            OP_LWU: begin
                value = {32'd0, lane_w};
            end
            // whole word, no selection
            OP_LD: begin
                value = rdata;
            end
            default: begin
                // not a load
                value = '0;
            end
        endcase
    end

endmodule

/* data_mem.sv */
`include "mem_stage_config.svh"

module data_mem import mem_stage_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    req,
    output logic [63:0] rdata
);

    localparam int unsigned WORDS = 1 << `MEM_DEPTH_LOG2;

    // ****************************************
    // storage
    // ****************************************

    logic [63:0] mem [WORDS];

    // word index, upper address bits dropped so the space wraps
    logic [`MEM_DEPTH_LOG2-1:0] index;

    assign index = req.addr[`MEM_INDEX_LSB +: `MEM_DEPTH_LOG2];

    // byte-strobed write, lands on the edge where wr_en is high
    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (req.wstrb[i]) begin
                    mem[index][i*8 +: 8] <= req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // ****************************************
    // read port
    // ****************************************

    // one cycle latency
    // register holds between reads so a stalled load keeps its data
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (req.rd_en) begin
            rdata <= mem[index];
        end
    end

    // ****************************************
    // checks
    // ****************************************

    // the stage issues one access per advance, never both kinds
    assert property (@(posedge clk) disable iff (rst)
        !(req.rd_en && req.wr_en))
        else $error("data_mem: read and write requested together");

endmodule

/* mem_stage.sv */
module mem_stage import mem_stage_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  ex_mem_t     in_bundle,
    output logic        out_valid,
    input  logic        out_ready,
    output mem_wb_t     out_bundle,
    output mem_req_t    mem_req,
    input  logic [63:0] mem_rdata
);

    // slot a holds the accepted bundle, slot b waits for write-back
    ex_mem_t     slot_a;
    ex_mem_t     slot_b;
    logic        a_valid;
    logic        b_valid;
    logic        in_fire;
    logic        out_fire;
    logic        advance;
    logic [63:0] st_wdata;
    logic [7:0]  st_wstrb;
    logic [63:0] ld_value;

    // ****************************************
    // handshakes and slot control
    // ****************************************

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // a moves to b when b is empty or leaving this edge
    assign advance   = a_valid && (!b_valid || out_fire);
    assign in_ready  = !a_valid || advance;
    assign out_valid = b_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                a_valid <= 1'b1;
            end else if (advance) begin
                a_valid <= 1'b0;
            end
            if (advance) begin
                b_valid <= 1'b1;
            end else if (out_fire) begin
                b_valid <= 1'b0;
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (in_fire) begin
            slot_a <= in_bundle;
        end
        if (advance) begin
            slot_b <= slot_a;
        end
    end

    // ****************************************
    // memory request from slot a
    // ****************************************

    store_align u_store_align (
        .op     (slot_a.op),
        .offset (slot_a.alu_out[2:0]),
        .src2   (slot_a.src2),
        .wdata  (st_wdata),
        .wstrb  (st_wstrb)
    );

    // single-cycle pulse on the advance edge
    // the read data is registered on the same edge slot b loads
    always_comb begin
        mem_req.rd_en = advance && op_is_load(slot_a.op);
        mem_req.wr_en = advance && op_is_store(slot_a.op);
        mem_req.addr  = slot_a.alu_out;
        mem_req.wdata = st_wdata;
        mem_req.wstrb = st_wstrb;
    end

    // ****************************************
    // write-back from slot b
    // ****************************************

    load_extract u_load_extract (
        .op     (slot_b.op),
        .offset (slot_b.alu_out[2:0]),
        .rdata  (mem_rdata),
        .value  (ld_value)
    );

    always_comb begin
        out_bundle.pc        = slot_b.pc;
        out_bundle.inst      = slot_b.inst;
        out_bundle.reg_wen   = 1'b1;
        out_bundle.reg_value = '0;
        case (slot_b.op)
            OP_ALU:  out_bundle.reg_value = slot_b.alu_out;
            // return address for jal and jalr
            OP_LINK: out_bundle.reg_value = slot_b.pc + 64'd4;
            OP_CSR:  out_bundle.reg_value = slot_b.src2;
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU: begin
                out_bundle.reg_value = ld_value;
            end
            // stores, branches, fences
            default: out_bundle.reg_wen = 1'b0;
        endcase
        // rd only meaningful with a register write
        out_bundle.reg_rd = out_bundle.reg_wen ? slot_b.inst[11:7] : 5'd0;
    end

    // ****************************************
    // checks
    // ****************************************

    // held bundle includes the load data kept by data_mem
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle))
        else $error("mem_stage: write-back bundle changed while stalled");

    // execute must hand over naturally aligned loads and stores only
    assert property (@(posedge clk) disable iff (rst)
        in_fire |-> op_aligned(in_bundle.op, in_bundle.alu_out[2:0]))
        else $error("mem_stage: misaligned access at %h", in_bundle.alu_out);

endmodule

/* mem_subsys_top.sv */
module mem_subsys_top import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    // from execute
    input  logic    in_valid,
    output logic    in_ready,
    input  ex_mem_t in_bundle,
    // to write-back
    output logic    out_valid,
    input  logic    out_ready,
    output mem_wb_t out_bundle
);

    // ****************************************
    // stage to memory
    // ****************************************

    mem_req_t    mem_req;
    // registered read data, one cycle behind rd_en
    logic [63:0] mem_rdata;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .rst   (rst),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

/* tb_checker.sv */
`include "mem_stage_config.svh"

module tb_checker import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  logic    in_ready,
    input  ex_mem_t in_bundle,
    input  logic    out_valid,
    input  logic    out_ready,
    input  mem_wb_t out_bundle,
    output int      pending,
    output int      errors,
    output int      checked
);

    localparam int WORDS = 1 << `MEM_DEPTH_LOG2;

    // reference copy of data_mem, updated in acceptance order
    logic [63:0] ref_mem [WORDS];
    bit          written [WORDS];
    mem_wb_t     expect_q [$];
    int          cycle;
    int          lone_cycle;
    bit          lone_pending;
    bit          in_reset;

    initial begin
        pending      = 0;
        errors       = 0;
        checked      = 0;
        cycle        = 0;
        lone_cycle   = 0;
        lone_pending = 1'b0;
        in_reset     = 1'b0;
    end

    // ****************************************
    // reference model
    // ****************************************

    // same wrap as the RAM, upper address bits dropped
    function automatic int word_index(input logic [63:0] addr);
        return int'(addr[`MEM_INDEX_LSB +: `MEM_DEPTH_LOG2]);
    endfunction

    // bytes touched by a memory op
    function automatic int access_size(input mem_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            OP_LD, OP_SD:         return 8;
            default:              return 0;
        endcase
    endfunction

    // src2 bytes land from the offset upward
    task automatic store_ref(input ex_mem_t b);
        int idx;
        int off;
        idx = word_index(b.alu_out);
        off = b.alu_out[2:0];
        for (int i = 0; i < access_size(b.op); i++) begin
            ref_mem[idx][(off + i) * 8 +: 8] = b.src2[i * 8 +: 8];
        end
        written[idx] = 1'b1;
    endtask

    // lane bytes first, then fill above with sign or zero
    function automatic logic [63:0] load_ref(input ex_mem_t b, input bit sign);
        logic [63:0] word;
        logic [63:0] v;
        int          size;
        int          off;
        word = ref_mem[word_index(b.alu_out)];
        size = access_size(b.op);
        off  = b.alu_out[2:0];
        v    = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < size) begin
                v[i * 8 +: 8] = word[(off + i) * 8 +: 8];
            end else if (sign && v[size * 8 - 1]) begin
                v[i * 8 +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic mem_wb_t expect_wb(input ex_mem_t b);
        mem_wb_t e;
        e.pc        = b.pc;
        e.inst      = b.inst;
        e.reg_wen   = 1'b1;
        e.reg_value = '0;
        case (b.op)
            OP_ALU:                     e.reg_value = b.alu_out;
            OP_LINK:                    e.reg_value = b.pc + 64'd4;
            OP_CSR:                     e.reg_value = b.src2;
            OP_LB, OP_LH, OP_LW, OP_LD: e.reg_value = load_ref(b, 1'b1);
            OP_LBU, OP_LHU, OP_LWU:     e.reg_value = load_ref(b, 1'b0);
            // stores and OP_NONE write no register
            default:                    e.reg_wen = 1'b0;
        endcase
        e.reg_rd = e.reg_wen ? b.inst[11:7] : 5'd0;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ****************************************
    // handshake monitor
    // ****************************************

    always @(posedge clk) begin : watch
        mem_wb_t exp;
        if (rst) begin
            in_reset = 1'b1;
        end else begin
            cycle++;
            // idle state right after reset
            if (in_reset && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
                errors++;
                $display("out_valid not low or in_ready not high after reset");
            end
            in_reset = 1'b0;
            // a bundle entering an empty stage shows up 2 cycles later
            if (lone_pending && cycle == lone_cycle + 1 && out_valid !== 1'b0) begin
                errors++;
                $display("bundle reached write-back 1 cycle after acceptance");
            end
            if (lone_pending && cycle == lone_cycle + 2) begin
                lone_pending = 1'b0;
                if (out_valid !== 1'b1) begin
                    errors++;
                    $display("bundle not at write-back 2 cycles after acceptance");
                end
            end
            // output side first, so a bundle leaving this edge frees its place
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("write-back transfer with no bundle outstanding");
                end else begin
                    exp = expect_q.pop_front();
                    checked++;
                    check_field("pc", out_bundle.pc, exp.pc);
                    check_field("inst", out_bundle.inst, exp.inst);
                    check_field("reg_wen", out_bundle.reg_wen, exp.reg_wen);
                    check_field("reg_rd", out_bundle.reg_rd, exp.reg_rd);
                    check_field("reg_value", out_bundle.reg_value, exp.reg_value);
                end
            end
            if (in_valid && in_ready) begin
                if (access_size(in_bundle.op) != 0 &&
                    in_bundle.op inside {OP_SB, OP_SH, OP_SW, OP_SD}) begin
                    store_ref(in_bundle);
                end else if (access_size(in_bundle.op) != 0 &&
                             !written[word_index(in_bundle.alu_out)]) begin
                    errors++;
                    $display("load from a word never written, address %h", in_bundle.alu_out);
                end
                expect_q.push_back(expect_wb(in_bundle));
                if (expect_q.size() == 1) begin
                    lone_pending = 1'b1;
                    lone_cycle   = cycle;
                end
            end
            pending = expect_q.size();
        end
    end

endmodule

/* tb_mem_subsys.sv */
`include "mem_stage_config.svh"

module tb_mem_subsys import mem_stage_pkg::*; ();

    localparam int RESET_CYCLES   = 8;
    localparam int ACCEPT_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT  = 256;
    // byte span of data_mem, adding it lands on the same word
    localparam logic [63:0] WRAP = 64'd1 << (`MEM_DEPTH_LOG2 + `MEM_INDEX_LSB);

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    ex_mem_t     in_bundle;
    logic        out_valid;
    logic        out_ready;
    mem_wb_t     out_bundle;
    int          pending;
    int          check_errors;
    int          checked;
    int          timeouts;
    bit          random_ready;
    logic [15:0] lfsr;
    ex_mem_t     stim [$];

    always #10 clk = ~clk;

    mem_subsys_top DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    tb_checker u_check (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .pending    (pending),
        .errors     (check_errors),
        .checked    (checked)
    );

    // ****************************************
    // back-pressure
    // ****************************************

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // stall when two fresh bits are both one, a quarter of cycles
    always @(negedge clk) begin
        logic b0;
        logic b1;
        if (random_ready) begin
            lfsr      = lfsr_next(lfsr);
            b0        = lfsr[0];
            lfsr      = lfsr_next(lfsr);
            b1        = lfsr[0];
            out_ready = !(b0 && b1);
        end else begin
            out_ready = 1'b1;
        end
    end

    // ****************************************
    // stimulus table
    // ****************************************

    task automatic add_entry(input mem_op_t op, input logic [63:0] addr,
                             input logic [63:0] src2);
        ex_mem_t e;
        int      n;
        n         = stim.size();
        e.spare   = 1'b0;
        e.pc      = 64'h8000_0000 + 64'(n * 4);
        // rd never zero, so a cleared reg_rd is visible
        e.inst    = {12'(n), 8'h5a, 5'(n % 31 + 1), 7'h33};
        e.op      = op;
        e.alu_out = addr;
        e.src2    = src2;
        stim.push_back(e);
    endtask

    task automatic build_table();
        // register write-back rules
        add_entry(OP_ALU, 64'h1111_2222_3333_4444, 64'h0);
        add_entry(OP_LINK, 64'h0, 64'h0);
        add_entry(OP_CSR, 64'h0, 64'hdead_beef_0bad_f00d);
        add_entry(OP_NONE, 64'h55, 64'h66);
        // doubleword round trip, then the same word through a wrapped address
        add_entry(OP_SD, 64'h100, 64'h0123_4567_89ab_cdef);
        add_entry(OP_LD, 64'h100, 64'h0);
        add_entry(OP_SD, 64'h100 + WRAP, 64'hfedc_ba98_7654_3210);
        add_entry(OP_LD, 64'h100, 64'h0);
        // partial stores over a known pattern, whole word read after each
        add_entry(OP_SD, 64'h200, 64'h1122_3344_5566_7788);
        add_entry(OP_SD, 64'h208, 64'h1122_3344_5566_7788);
        add_entry(OP_SD, 64'h210, 64'h1122_3344_5566_7788);
        for (int off = 0; off < 8; off++) begin
            add_entry(OP_SB, 64'h200 + 64'(off), 64'hcafe_f00d_1234_5600 + 64'(8'h81 + off * 17));
            add_entry(OP_LD, 64'h200, 64'h0);
        end
        for (int off = 0; off < 8; off += 2) begin
            add_entry(OP_SH, 64'h208 + 64'(off), 64'hcafe_f00d_1234_0000 + 64'(16'h8001 + off * 257));
            add_entry(OP_LD, 64'h208, 64'h0);
        end
        for (int off = 0; off < 8; off += 4) begin
            add_entry(OP_SW, 64'h210 + 64'(off), 64'hcafe_f00d_0000_0000 +
                      64'(32'h8000_0001 + off * 32'h0101_0101));
            add_entry(OP_LD, 64'h210, 64'h0);
        end
        // mixed top bits, every lane loaded signed and unsigned
        add_entry(OP_SD, 64'h300, 64'h80ff_7f9a_c3d4_8e85);
        for (int off = 0; off < 8; off++) begin
            add_entry(OP_LB, 64'h300 + 64'(off), 64'h0);
            add_entry(OP_LBU, 64'h300 + 64'(off), 64'h0);
            if (off % 2 == 0) begin
                add_entry(OP_LH, 64'h300 + 64'(off), 64'h0);
                add_entry(OP_LHU, 64'h300 + 64'(off), 64'h0);
            end
            if (off % 4 == 0) begin
                add_entry(OP_LW, 64'h300 + 64'(off), 64'h0);
                add_entry(OP_LWU, 64'h300 + 64'(off), 64'h0);
            end
        end
    endtask

    // ****************************************
    // driver
    // ****************************************

    // starts and ends on a falling edge, valid held until accepted
    task automatic send_entry(input ex_mem_t e, input int n, output bit timed_out);
        int waited;
        bit accepted;
        waited    = 0;
        in_bundle = e;
        in_valid  = 1'b1;
        do begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end while (!accepted && waited < ACCEPT_TIMEOUT);
        @(negedge clk);
        in_valid  = 1'b0;
        timed_out = !accepted;
        if (timed_out) begin
            timeouts++;
            $display("bundle %0d was not accepted within %0d cycles", n, ACCEPT_TIMEOUT);
        end
    endtask

    // pending moves on rising edges, read it on falling ones
    task automatic wait_drain(output bit timed_out);
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        timed_out = (pending != 0);
        if (timed_out) begin
            timeouts++;
            $display("%0d bundles never reached write-back", pending);
        end
    endtask

    initial begin
        bit timed_out;
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_bundle    = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        lfsr         = 16'd64;
        timeouts     = 0;
        timed_out    = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < stim.size() && !timed_out; i++) begin
            send_entry(stim[i], i, timed_out);
            // first bundle runs alone with out_ready high
            if (i == 0 && !timed_out) begin
                wait_drain(timed_out);
                random_ready <= 1'b1;
            end
        end
        if (!timed_out) begin
            wait_drain(timed_out);
        end
        $display("errors: %0d, timeouts: %0d, bundles checked: %0d of %0d",
                 check_errors, timeouts, checked, stim.size());
        if (check_errors == 0 && timeouts == 0 && checked == stim.size()) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
mem_stage_pkg.sv
store_align.sv
load_extract.sv
data_mem.sv
mem_stage.sv
mem_subsys_top.sv
tb_checker.sv
tb_mem_subsys.sv
